//--- render_pkg.sv
package render_pkg;

  // Default fixed-point format, one integer sign bit plus fraction
  localparam int DEF_FRAC_BITS = 14;

  // World coordinates and camera position
  localparam int DEF_C_WIDTH = 18;

  // Camera basis vector components
  localparam int DEF_N_WIDTH = 16;

  // Divider sequencing
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_t;

  // Projection unit sequencing
  typedef enum logic {
    IDLE,
    COMPUTE
  } proj_state_t;

endpackage

//--- fixed_point_div.sv
`timescale 1ns/100ps

module fixed_point_div #(
  parameter int WIDTH = 32,
  parameter int FRAC_BITS = render_pkg::DEF_FRAC_BITS
) (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    start,
  input  logic signed [WIDTH-1:0] dividend,
  input  logic signed [WIDTH-1:0] divisor,
  output logic                    done,
  output logic                    zerodiv,
  output logic                    overflow,
  output logic signed [WIDTH-1:0] quotient
);
  import render_pkg::*;

  localparam int CNT_WIDTH = $clog2(WIDTH);

  div_state_t state;
  logic [CNT_WIDTH-1:0] count;
  logic [WIDTH-1:0] dividend_mag;
  logic [WIDTH-1:0] divisor_mag;
  logic [WIDTH+FRAC_BITS-1:0] numerator;
  logic [WIDTH-1:0] rem;
  logic [WIDTH-1:0] work;
  logic [WIDTH-1:0] dvsr;
  logic [WIDTH:0] trial;
  logic [WIDTH:0] trial_sub;
  logic trial_ge;
  logic negative;
  logic zero_flag;
  logic early_ovf;

  assign dividend_mag = dividend[WIDTH-1] ? -dividend : dividend;
  assign divisor_mag = divisor[WIDTH-1] ? -divisor : divisor;
  assign numerator = {dividend_mag, {FRAC_BITS{1'b0}}};

  // Restoring step, next numerator bit enters from the top of work
  assign trial = {rem, work[WIDTH-1]};
  assign trial_sub = trial - {1'b0, dvsr};
  assign trial_ge = trial >= {1'b0, dvsr};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= DIV_IDLE;
      count <= '0;
      done <= 1'b0;
      zerodiv <= 1'b0;
      overflow <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        DIV_IDLE: begin
          if (start) begin
            count <= '0;
            state <= (divisor == '0) ? DIV_DONE : DIV_RUN;
          end
        end
        DIV_RUN: begin
          count <= count + 1'b1;
          if (count == CNT_WIDTH'(WIDTH - 1)) begin
            state <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          done <= 1'b1;
          zerodiv <= zero_flag;
          overflow <= !zero_flag && (early_ovf || work[WIDTH-1]);
          state <= DIV_IDLE;
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == DIV_IDLE && start) begin
      negative <= dividend[WIDTH-1] ^ divisor[WIDTH-1];
      zero_flag <= (divisor == '0);
      dvsr <= divisor_mag;
      // Upper fraction bits seed the remainder, quotient bits above WIDTH mean overflow
      rem <= WIDTH'(numerator[WIDTH+FRAC_BITS-1:WIDTH]);
      work <= numerator[WIDTH-1:0];
      early_ovf <= WIDTH'(numerator[WIDTH+FRAC_BITS-1:WIDTH]) >= divisor_mag;
    end else if (state == DIV_RUN) begin
      rem <= trial_ge ? trial_sub[WIDTH-1:0] : trial[WIDTH-1:0];
      work <= {work[WIDTH-2:0], trial_ge};
    end else if (state == DIV_DONE) begin
      quotient <= zero_flag ? '0 : (negative ? -work : work);
    end
  end

endmodule

//--- camera_transform.sv
`timescale 1ns/100ps

module camera_transform #(
  parameter int FRAC_BITS = render_pkg::DEF_FRAC_BITS,
  parameter int C_WIDTH = render_pkg::DEF_C_WIDTH,
  parameter int N_WIDTH = render_pkg::DEF_N_WIDTH
) (
  input  logic                                     clk_in,
  input  logic                                     rst_in,
  input  logic                                     point_valid,
  input  logic signed [C_WIDTH-1:0]                point_x,
  input  logic signed [C_WIDTH-1:0]                point_y,
  input  logic signed [C_WIDTH-1:0]                point_z,
  input  logic signed [C_WIDTH-1:0]                cam_x,
  input  logic signed [C_WIDTH-1:0]                cam_y,
  input  logic signed [C_WIDTH-1:0]                cam_z,
  input  logic signed [N_WIDTH-1:0]                u_x,
  input  logic signed [N_WIDTH-1:0]                u_y,
  input  logic signed [N_WIDTH-1:0]                u_z,
  input  logic signed [N_WIDTH-1:0]                v_x,
  input  logic signed [N_WIDTH-1:0]                v_y,
  input  logic signed [N_WIDTH-1:0]                v_z,
  input  logic signed [N_WIDTH-1:0]                w_x,
  input  logic signed [N_WIDTH-1:0]                w_y,
  input  logic signed [N_WIDTH-1:0]                w_z,
  input  logic                                     ready_in,
  output logic                                     ready_out,
  output logic                                     ndc_valid,
  output logic signed [C_WIDTH+N_WIDTH-FRAC_BITS+1:0] ndc_x,
  output logic signed [C_WIDTH+N_WIDTH-FRAC_BITS+1:0] ndc_y,
  output logic signed [C_WIDTH+N_WIDTH-FRAC_BITS+1:0] ndc_z
);

  localparam int D_WIDTH = C_WIDTH + N_WIDTH - FRAC_BITS + 2;
  localparam int SUM_WIDTH = C_WIDTH + N_WIDTH + 3;

  logic s1_valid;
  logic accept;
  logic signed [C_WIDTH:0] dx;
  logic signed [C_WIDTH:0] dy;
  logic signed [C_WIDTH:0] dz;
  logic signed [SUM_WIDTH-1:0] dot_x;
  logic signed [SUM_WIDTH-1:0] dot_y;
  logic signed [SUM_WIDTH-1:0] dot_z;

  function automatic logic signed [SUM_WIDTH-1:0] dot3(
    input logic signed [C_WIDTH:0]   a0,
    input logic signed [C_WIDTH:0]   a1,
    input logic signed [C_WIDTH:0]   a2,
    input logic signed [N_WIDTH-1:0] b0,
    input logic signed [N_WIDTH-1:0] b1,
    input logic signed [N_WIDTH-1:0] b2
  );
    logic signed [SUM_WIDTH-1:0] acc;
    acc = a0 * b0 + a1 * b1 + a2 * b2;
    return acc;
  endfunction

  // One point at a time, only while downstream can take it
  assign ready_out = ready_in && !s1_valid && !ndc_valid;
  assign accept = point_valid && ready_out;

  // Rescale back to FRAC_BITS fraction bits
  assign dot_x = dot3(dx, dy, dz, u_x, u_y, u_z) >>> FRAC_BITS;
  assign dot_y = dot3(dx, dy, dz, v_x, v_y, v_z) >>> FRAC_BITS;
  assign dot_z = dot3(dx, dy, dz, w_x, w_y, w_z) >>> FRAC_BITS;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid <= 1'b0;
      ndc_valid <= 1'b0;
    end else begin
      s1_valid <= accept;
      ndc_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept) begin
      dx <= point_x - cam_x;
      dy <= point_y - cam_y;
      dz <= point_z - cam_z;
    end
    if (s1_valid) begin
      ndc_x <= dot_x[D_WIDTH-1:0];
      ndc_y <= dot_y[D_WIDTH-1:0];
      ndc_z <= dot_z[D_WIDTH-1:0];
    end
  end

endmodule

//--- projection_3d_to_2d.sv
`timescale 1ns/100ps

module projection_3d_to_2d #(
  parameter int FRAC_BITS = render_pkg::DEF_FRAC_BITS,
  parameter int C_WIDTH = render_pkg::DEF_C_WIDTH,
  parameter int N_WIDTH = render_pkg::DEF_N_WIDTH
) (
  input  logic                                         clk_in,
  input  logic                                         rst_in,
  input  logic                                         valid_in,
  input  logic signed [C_WIDTH+N_WIDTH-FRAC_BITS+1:0]  ndc_x,
  input  logic signed [C_WIDTH+N_WIDTH-FRAC_BITS+1:0]  ndc_y,
  input  logic signed [C_WIDTH+N_WIDTH-FRAC_BITS+1:0]  ndc_z,
  output logic                                         ready_out,
  output logic                                         valid_out,
  output logic signed [2*(C_WIDTH+N_WIDTH-FRAC_BITS)+4:0] x_renorm,
  output logic signed [2*(C_WIDTH+N_WIDTH-FRAC_BITS)+4:0] y_renorm,
  output logic signed [C_WIDTH+N_WIDTH-FRAC_BITS+1:0]  z
);
  import render_pkg::*;

  localparam int D_WIDTH = C_WIDTH + N_WIDTH - FRAC_BITS + 2;
  localparam int R_WIDTH = 2 * D_WIDTH + 1;
  localparam logic signed [R_WIDTH-1:0] LIMIT = R_WIDTH'(1) << FRAC_BITS;

  proj_state_t state;
  logic depth_ok;
  logic depth_bad;
  logic div_start;
  logic signed [R_WIDTH-1:0] x_dividend;
  logic signed [R_WIDTH-1:0] y_dividend;
  logic signed [R_WIDTH-1:0] z_divisor;
  logic x_done;
  logic y_done;
  logic x_zerodiv;
  logic y_zerodiv;
  logic x_overflow;
  logic y_overflow;
  logic signed [R_WIDTH-1:0] x_quot;
  logic signed [R_WIDTH-1:0] y_quot;
  logic x_seen;
  logic y_seen;
  logic finish;
  logic in_frustum;
  logic div_fault;
  logic signed [D_WIDTH-1:0] z_hold;

  assign depth_ok = (ndc_z > 0);
  // Points behind the camera never reach the dividers
  assign div_start = (state == IDLE) && valid_in && depth_ok;

  assign x_dividend = {{(R_WIDTH-D_WIDTH){ndc_x[D_WIDTH-1]}}, ndc_x};
  assign y_dividend = {{(R_WIDTH-D_WIDTH){ndc_y[D_WIDTH-1]}}, ndc_y};
  assign z_divisor = {{(R_WIDTH-D_WIDTH){ndc_z[D_WIDTH-1]}}, ndc_z};

  fixed_point_div #(
    .WIDTH(R_WIDTH),
    .FRAC_BITS(FRAC_BITS)
  ) x_renormalization (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .start(div_start),
    .dividend(x_dividend),
    .divisor(z_divisor),
    .done(x_done),
    .zerodiv(x_zerodiv),
    .overflow(x_overflow),
    .quotient(x_quot)
  );

  fixed_point_div #(
    .WIDTH(R_WIDTH),
    .FRAC_BITS(FRAC_BITS)
  ) y_renormalization (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .start(div_start),
    .dividend(y_dividend),
    .divisor(z_divisor),
    .done(y_done),
    .zerodiv(y_zerodiv),
    .overflow(y_overflow),
    .quotient(y_quot)
  );

  assign finish = (state == COMPUTE) && !depth_bad && (x_done || x_seen) && (y_done || y_seen);
  assign div_fault = x_zerodiv || y_zerodiv || x_overflow || y_overflow;
  // Strictly inside the unit square
  assign in_frustum = (x_quot < LIMIT) && (x_quot > -LIMIT) &&
                      (y_quot < LIMIT) && (y_quot > -LIMIT);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      ready_out <= 1'b1;
      valid_out <= 1'b0;
      depth_bad <= 1'b0;
      x_seen <= 1'b0;
      y_seen <= 1'b0;
    end else begin
      valid_out <= 1'b0;
      case (state)
        IDLE: begin
          if (valid_in) begin
            state <= COMPUTE;
            ready_out <= 1'b0;
            depth_bad <= !depth_ok;
            x_seen <= 1'b0;
            y_seen <= 1'b0;
          end
        end
        COMPUTE: begin
          if (depth_bad || finish) begin
            state <= IDLE;
            ready_out <= 1'b1;
            valid_out <= finish && !div_fault && in_frustum;
          end else begin
            x_seen <= x_seen || x_done;
            y_seen <= y_seen || y_done;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (div_start) begin
      z_hold <= ndc_z;
    end
    if (finish) begin
      x_renorm <= x_quot;
      y_renorm <= y_quot;
      z <= z_hold;
    end
  end

endmodule

//--- viewport_map.sv
`timescale 1ns/100ps

module viewport_map #(
  parameter int FRAC_BITS = render_pkg::DEF_FRAC_BITS,
  parameter int D_WIDTH = render_pkg::DEF_C_WIDTH + render_pkg::DEF_N_WIDTH -
                          render_pkg::DEF_FRAC_BITS + 2,
  parameter int R_WIDTH = 2 * D_WIDTH + 1,
  parameter int VIEWPORT_W = 320,
  parameter int VIEWPORT_H = 240
) (
  input  logic                            clk_in,
  input  logic                            rst_in,
  input  logic                            valid_in,
  input  logic signed [R_WIDTH-1:0]       x_renorm,
  input  logic signed [R_WIDTH-1:0]       y_renorm,
  input  logic signed [D_WIDTH-1:0]       z,
  output logic                            pixel_valid,
  output logic [$clog2(VIEWPORT_W)-1:0]   hcount,
  output logic [$clog2(VIEWPORT_H)-1:0]   vcount,
  output logic signed [D_WIDTH-1:0]       depth
);

  localparam int H_WIDTH = $clog2(VIEWPORT_W);
  localparam int V_WIDTH = $clog2(VIEWPORT_H);
  localparam int P_WIDTH = R_WIDTH + ((H_WIDTH > V_WIDTH) ? H_WIDTH : V_WIDTH) + 3;
  localparam logic signed [P_WIDTH-1:0] LIMIT = P_WIDTH'(1) << FRAC_BITS;
  localparam logic signed [P_WIDTH-1:0] W_SCALE = P_WIDTH'(VIEWPORT_W);
  localparam logic signed [P_WIDTH-1:0] H_SCALE = P_WIDTH'(VIEWPORT_H);

  logic signed [P_WIDTH-1:0] x_offset;
  logic signed [P_WIDTH-1:0] y_offset;
  logic signed [P_WIDTH-1:0] x_pixel;
  logic signed [P_WIDTH-1:0] y_pixel;

  // Shift range (-1, 1) to (0, 2), row 0 at the top
  assign x_offset = P_WIDTH'(x_renorm) + LIMIT;
  assign y_offset = LIMIT - P_WIDTH'(y_renorm);

  // Divide by two as well to land in (0, size)
  assign x_pixel = (x_offset * W_SCALE) >>> (FRAC_BITS + 1);
  assign y_pixel = (y_offset * H_SCALE) >>> (FRAC_BITS + 1);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= valid_in;
    end
  end

  always_ff @(posedge clk_in) begin
    if (valid_in) begin
      hcount <= x_pixel[H_WIDTH-1:0];
      vcount <= y_pixel[V_WIDTH-1:0];
      depth <= z;
    end
  end

endmodule

//--- vertex_pipeline.sv
`timescale 1ns/100ps

module vertex_pipeline #(
  parameter int FRAC_BITS = render_pkg::DEF_FRAC_BITS,
  parameter int C_WIDTH = render_pkg::DEF_C_WIDTH,
  parameter int N_WIDTH = render_pkg::DEF_N_WIDTH,
  parameter int VIEWPORT_W = 320,
  parameter int VIEWPORT_H = 240
) (
  input  logic                                        clk_in,
  input  logic                                        rst_in,
  input  logic                                        point_valid,
  input  logic signed [C_WIDTH-1:0]                   point_x,
  input  logic signed [C_WIDTH-1:0]                   point_y,
  input  logic signed [C_WIDTH-1:0]                   point_z,
  input  logic signed [C_WIDTH-1:0]                   cam_x,
  input  logic signed [C_WIDTH-1:0]                   cam_y,
  input  logic signed [C_WIDTH-1:0]                   cam_z,
  input  logic signed [N_WIDTH-1:0]                   u_x,
  input  logic signed [N_WIDTH-1:0]                   u_y,
  input  logic signed [N_WIDTH-1:0]                   u_z,
  input  logic signed [N_WIDTH-1:0]                   v_x,
  input  logic signed [N_WIDTH-1:0]                   v_y,
  input  logic signed [N_WIDTH-1:0]                   v_z,
  input  logic signed [N_WIDTH-1:0]                   w_x,
  input  logic signed [N_WIDTH-1:0]                   w_y,
  input  logic signed [N_WIDTH-1:0]                   w_z,
  output logic                                        ready,
  output logic                                        pixel_valid,
  output logic [$clog2(VIEWPORT_W)-1:0]               hcount,
  output logic [$clog2(VIEWPORT_H)-1:0]               vcount,
  output logic signed [C_WIDTH+N_WIDTH-FRAC_BITS+1:0] depth
);

  localparam int D_WIDTH = C_WIDTH + N_WIDTH - FRAC_BITS + 2;
  localparam int R_WIDTH = 2 * D_WIDTH + 1;

  logic proj_ready;
  logic ndc_valid;
  logic signed [D_WIDTH-1:0] ndc_x;
  logic signed [D_WIDTH-1:0] ndc_y;
  logic signed [D_WIDTH-1:0] ndc_z;
  logic proj_valid;
  logic signed [R_WIDTH-1:0] x_renorm;
  logic signed [R_WIDTH-1:0] y_renorm;
  logic signed [D_WIDTH-1:0] z;

  camera_transform #(
    .FRAC_BITS(FRAC_BITS),
    .C_WIDTH(C_WIDTH),
    .N_WIDTH(N_WIDTH)
  ) camera (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .point_valid(point_valid),
    .point_x(point_x),
    .point_y(point_y),
    .point_z(point_z),
    .cam_x(cam_x),
    .cam_y(cam_y),
    .cam_z(cam_z),
    .u_x(u_x),
    .u_y(u_y),
    .u_z(u_z),
    .v_x(v_x),
    .v_y(v_y),
    .v_z(v_z),
    .w_x(w_x),
    .w_y(w_y),
    .w_z(w_z),
    .ready_in(proj_ready),
    .ready_out(ready),
    .ndc_valid(ndc_valid),
    .ndc_x(ndc_x),
    .ndc_y(ndc_y),
    .ndc_z(ndc_z)
  );

  projection_3d_to_2d #(
    .FRAC_BITS(FRAC_BITS),
    .C_WIDTH(C_WIDTH),
    .N_WIDTH(N_WIDTH)
  ) projection (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(ndc_valid),
    .ndc_x(ndc_x),
    .ndc_y(ndc_y),
    .ndc_z(ndc_z),
    .ready_out(proj_ready),
    .valid_out(proj_valid),
    .x_renorm(x_renorm),
    .y_renorm(y_renorm),
    .z(z)
  );

  viewport_map #(
    .FRAC_BITS(FRAC_BITS),
    .D_WIDTH(D_WIDTH),
    .R_WIDTH(R_WIDTH),
    .VIEWPORT_W(VIEWPORT_W),
    .VIEWPORT_H(VIEWPORT_H)
  ) viewport (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(proj_valid),
    .x_renorm(x_renorm),
    .y_renorm(y_renorm),
    .z(z),
    .pixel_valid(pixel_valid),
    .hcount(hcount),
    .vcount(vcount),
    .depth(depth)
  );

endmodule

//--- tb_vertex_pipeline.sv
`timescale 1ns/100ps

module tb_vertex_pipeline;
  import render_pkg::*;

  localparam int FRAC_BITS = DEF_FRAC_BITS;
  localparam int C_WIDTH = DEF_C_WIDTH;
  localparam int N_WIDTH = DEF_N_WIDTH;
  localparam int VIEWPORT_W = 320;
  localparam int VIEWPORT_H = 240;
  localparam int D_WIDTH = C_WIDTH + N_WIDTH - FRAC_BITS + 2;
  localparam int Q_WIDTH = 2 * D_WIDTH + 1;
  localparam int H_WIDTH = $clog2(VIEWPORT_W);
  localparam int V_WIDTH = $clog2(VIEWPORT_H);
  localparam int E_WIDTH = H_WIDTH + V_WIDTH + D_WIDTH;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_CYCLES = 300 * (Q_WIDTH + 8) + RESET_CYCLES;
  localparam longint LIMIT = longint'(1) <<< FRAC_BITS;
  localparam int ONE = 1 << FRAC_BITS;

  logic clk_in;
  logic rst_in;
  logic point_valid;
  logic signed [C_WIDTH-1:0] point_x;
  logic signed [C_WIDTH-1:0] point_y;
  logic signed [C_WIDTH-1:0] point_z;
  logic signed [C_WIDTH-1:0] cam_x;
  logic signed [C_WIDTH-1:0] cam_y;
  logic signed [C_WIDTH-1:0] cam_z;
  logic signed [N_WIDTH-1:0] u_x;
  logic signed [N_WIDTH-1:0] u_y;
  logic signed [N_WIDTH-1:0] u_z;
  logic signed [N_WIDTH-1:0] v_x;
  logic signed [N_WIDTH-1:0] v_y;
  logic signed [N_WIDTH-1:0] v_z;
  logic signed [N_WIDTH-1:0] w_x;
  logic signed [N_WIDTH-1:0] w_y;
  logic signed [N_WIDTH-1:0] w_z;
  logic ready;
  logic pixel_valid;
  logic [H_WIDTH-1:0] hcount;
  logic [V_WIDTH-1:0] vcount;
  logic signed [D_WIDTH-1:0] depth;

  // Expected {hcount, vcount, depth} per accepted point, in order
  logic [E_WIDTH-1:0] expected_q[$];
  logic [E_WIDTH-1:0] exp_pixel;
  int errors = 0;
  int checks = 0;
  int pixel_count = 0;
  int predicted = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int test_num = 0;
  int test_errors = 0;
  int cycle_count = 0;
  integer seed = 32'h84bc;

  vertex_pipeline #(
    .FRAC_BITS(FRAC_BITS),
    .C_WIDTH(C_WIDTH),
    .N_WIDTH(N_WIDTH),
    .VIEWPORT_W(VIEWPORT_W),
    .VIEWPORT_H(VIEWPORT_H)
  ) dut0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .point_valid(point_valid),
    .point_x(point_x),
    .point_y(point_y),
    .point_z(point_z),
    .cam_x(cam_x),
    .cam_y(cam_y),
    .cam_z(cam_z),
    .u_x(u_x),
    .u_y(u_y),
    .u_z(u_z),
    .v_x(v_x),
    .v_y(v_y),
    .v_z(v_z),
    .w_x(w_x),
    .w_y(w_y),
    .w_z(w_z),
    .ready(ready),
    .pixel_valid(pixel_valid),
    .hcount(hcount),
    .vcount(vcount),
    .depth(depth)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  // Camera-space values keep only D_WIDTH bits
  function automatic longint to_depth_width(input longint v);
    longint m;
    m = v & ((longint'(1) <<< D_WIDTH) - 1);
    if (m >= (longint'(1) <<< (D_WIDTH - 1))) begin
      m = m - (longint'(1) <<< D_WIDTH);
    end
    return m;
  endfunction

  // Top bit set when the point reaches the screen
  function automatic logic [E_WIDTH:0] expected_pixel(input longint px, input longint py,
                                                      input longint pz);
    longint dx;
    longint dy;
    longint dz;
    longint ex;
    longint ey;
    longint ez;
    longint qx;
    longint qy;
    longint hc;
    longint vc;
    dx = px - longint'(cam_x);
    dy = py - longint'(cam_y);
    dz = pz - longint'(cam_z);
    ex = to_depth_width((dx * u_x + dy * u_y + dz * u_z) >>> FRAC_BITS);
    ey = to_depth_width((dx * v_x + dy * v_y + dz * v_z) >>> FRAC_BITS);
    ez = to_depth_width((dx * w_x + dy * w_y + dz * w_z) >>> FRAC_BITS);
    if (ez <= 0) begin
      return '0;
    end
    // Signed division truncates toward zero
    qx = (ex * LIMIT) / ez;
    qy = (ey * LIMIT) / ez;
    if (qx >= (longint'(1) <<< (Q_WIDTH - 1)) || -qx >= (longint'(1) <<< (Q_WIDTH - 1)) ||
        qy >= (longint'(1) <<< (Q_WIDTH - 1)) || -qy >= (longint'(1) <<< (Q_WIDTH - 1))) begin
      return '0;
    end
    if (qx >= LIMIT || qx <= -LIMIT || qy >= LIMIT || qy <= -LIMIT) begin
      return '0;
    end
    hc = ((qx + LIMIT) * VIEWPORT_W) >>> (FRAC_BITS + 1);
    vc = ((LIMIT - qy) * VIEWPORT_H) >>> (FRAC_BITS + 1);
    return {1'b1, hc[H_WIDTH-1:0], vc[V_WIDTH-1:0], ez[D_WIDTH-1:0]};
  endfunction

  // Output comparator, samples away from the active edge
  always @(negedge clk_in) begin
    if (!rst_in && pixel_valid) begin
      pixel_count++;
      if (expected_q.size() == 0) begin
        $display("Unexpected pixel_valid at %0t with no accepted point pending", $time);
        errors++;
      end else begin
        exp_pixel = expected_q.pop_front();
        checks++;
        if (hcount !== exp_pixel[E_WIDTH-1 -: H_WIDTH] ||
            vcount !== exp_pixel[D_WIDTH +: V_WIDTH] ||
            depth !== exp_pixel[D_WIDTH-1:0]) begin
          $display("CHECK FAILED at %0t: pixel (%0d, %0d) depth %0d, expected (%0d, %0d) %0d",
                   $time, hcount, vcount, depth, exp_pixel[E_WIDTH-1 -: H_WIDTH],
                   exp_pixel[D_WIDTH +: V_WIDTH], $signed(exp_pixel[D_WIDTH-1:0]));
          errors++;
        end
      end
    end
  end

  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the pipeline stopped responding", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  task automatic set_camera(input int cx, input int cy, input int cz, input bit rotated);
    @(posedge clk_in);
    cam_x <= cx;
    cam_y <= cy;
    cam_z <= cz;
    // Rotated basis looks along world +x
    u_x <= 0;
    u_y <= 0;
    u_z <= rotated ? -ONE : 0;
    v_x <= 0;
    v_y <= ONE;
    v_z <= 0;
    w_x <= rotated ? ONE : 0;
    w_y <= 0;
    w_z <= rotated ? 0 : ONE;
    if (!rotated) begin
      u_x <= ONE;
    end
  endtask

  task automatic send_point(input int px, input int py, input int pz);
    logic [E_WIDTH:0] result;
    @(negedge clk_in);
    while (!ready) begin
      @(negedge clk_in);
    end
    result = expected_pixel(px, py, pz);
    if (result[E_WIDTH]) begin
      expected_q.push_back(result[E_WIDTH-1:0]);
      predicted++;
    end
    @(posedge clk_in);
    point_valid <= 1'b1;
    point_x <= px;
    point_y <= py;
    point_z <= pz;
    @(posedge clk_in);
    point_valid <= 1'b0;
  endtask

  // Pixel follows one cycle after ready returns
  task automatic wait_idle();
    @(negedge clk_in);
    while (!ready) begin
      @(negedge clk_in);
    end
    repeat (4) @(negedge clk_in);
  endtask

  task automatic begin_test();
    test_num++;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    wait_idle();
    if (expected_q.size() != 0) begin
      $display("%0d expected pixels never appeared in test %0d", expected_q.size(), test_num);
      errors++;
      expected_q.delete();
    end
    if (errors == test_errors) begin
      tests_passed++;
      $display("test %0d %s: passed", test_num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", test_num, name, errors - test_errors);
    end
  endtask

  initial begin
    int i;
    int b;
    int cx;
    int cy;
    int cz;
    int ox;
    int oy;
    int oz;
    int start_pixels;
    int start_predicted;
    rst_in = 1'b1;
    point_valid = 1'b0;
    point_x = '0;
    point_y = '0;
    point_z = '0;
    cam_x = '0;
    cam_y = '0;
    cam_z = '0;
    u_x = ONE;
    u_y = '0;
    u_z = '0;
    v_x = '0;
    v_y = ONE;
    v_z = '0;
    w_x = '0;
    w_y = '0;
    w_z = ONE;
    repeat (RESET_CYCLES) @(posedge clk_in);
    rst_in <= 1'b0;

    begin_test();
    repeat (20) begin
      @(negedge clk_in);
      if (ready !== 1'b1) begin
        $display("CHECK FAILED at %0t: ready is %b after reset", $time, ready);
        errors++;
      end
    end
    end_test("after reset");

    begin_test();
    set_camera(0, 0, 0, 1'b0);
    send_point(0, 0, ONE);
    send_point(ONE / 2, ONE / 4, ONE);
    send_point(-ONE / 2, -ONE / 2, 2 * ONE);
    send_point(3 * ONE, -5 * ONE, 7 * ONE);
    send_point(123, -4567, ONE / 3);
    end_test("identity camera");

    begin_test();
    send_point(0, 0, 0);
    send_point(ONE / 4, 0, -ONE);
    send_point(0, 0, -1);
    send_point(ONE / 8, ONE / 8, ONE);
    end_test("behind camera");

    begin_test();
    send_point(ONE, 0, ONE);
    send_point(0, -ONE, ONE);
    send_point(-2 * ONE, 0, ONE);
    send_point(0, 3 * ONE, 2 * ONE);
    send_point(ONE - 1, 1 - ONE, ONE);
    end_test("outside frustum");

    begin_test();
    set_camera(ONE, ONE / 2, -2 * ONE, 1'b1);
    send_point(3 * ONE, ONE / 2, -2 * ONE);
    send_point(2 * ONE, ONE, -5 * ONE / 2);
    send_point(5 * ONE, -ONE, -ONE);
    send_point(ONE / 2, 0, -2 * ONE);
    end_test("rotated camera");

    begin_test();
    start_pixels = pixel_count;
    start_predicted = predicted;
    for (b = 0; b < 4; b++) begin
      wait_idle();
      cx = $random(seed) % 32768;
      cy = $random(seed) % 32768;
      cz = $random(seed) % 32768;
      set_camera(cx, cy, cz, b[0]);
      for (i = 0; i < 50; i++) begin
        ox = $random(seed) % 65536;
        oy = $random(seed) % 65536;
        // Mostly in front, a few at or behind the camera
        oz = int'($unsigned($random(seed)) % 65536) - 6000;
        if (b[0]) begin
          send_point(cx + oz, cy + oy, cz + ox);
        end else begin
          send_point(cx + ox, cy + oy, cz + oz);
        end
      end
    end
    wait_idle();
    if (pixel_count - start_pixels != predicted - start_predicted) begin
      $display("Random test produced %0d pixels, %0d were predicted",
               pixel_count - start_pixels, predicted - start_predicted);
      errors++;
    end
    end_test("random points");

    $display("tests passed %0d, failed %0d, pixels checked %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- build.f
render_pkg.sv
fixed_point_div.sv
camera_transform.sv
projection_3d_to_2d.sv
viewport_map.sv
vertex_pipeline.sv
tb_vertex_pipeline.sv

//--- Bender.yml
package:
  name: vertex_pipeline

sources:
  - render_pkg.sv
  - fixed_point_div.sv
  - camera_transform.sv
  - projection_3d_to_2d.sv
  - viewport_map.sv
  - vertex_pipeline.sv
  - target: simulation
    files:
      - tb_vertex_pipeline.sv
